/* list.f */
+incdir+.
adc_ctrl_pkg.sv
reg_bus_decode.sv
adc_serial_ctrl.sv
reg_readback.sv
adc_ctrl_top.sv
tb_ads_model.sv
tb_adc_ctrl_top.sv

/* tb_adc_ctrl_top.sv */
`timescale 1ns/1ps
`include "adc_ctrl_config.svh"

module tb_adc_ctrl_top;

  import adc_ctrl_pkg::*;

  localparam reg_addr_t ADC_A  = reg_addr_t'(`ADC_CTRL_ADDR);
  localparam reg_addr_t VMAG_A = reg_addr_t'(`VMAG_CTRL_ADDR);

  logic      clk_usb;
  logic      reset_i;
  reg_req_t  reg_req;
  reg_byte_t reg_datao;
  adc_pins_t adc_pins;
  logic      adc_sdout;
  vmag_t     vmag_d;
  logic      use_model;    // sdout from the ADC model, else random level
  logic      rand_sdout;
  logic      model_sdout;
  adc_pins_t exp_pins;     // reference state
  reg_byte_t exp_capture;
  vmag_t     exp_vmag;
  int        errors = 0;
  int        checks = 0;
  int        tests_run = 0;
  int        tests_failed = 0;
  int        err_base = 0;  // errors before the current test

  assign adc_sdout = use_model ? model_sdout : rand_sdout;

  adc_ctrl_top u_dut (
    .clk_usb   (clk_usb),
    .reset_i   (reset_i),
    .reg_req   (reg_req),
    .reg_datao (reg_datao),
    .adc_pins  (adc_pins),
    .adc_sdout (adc_sdout),
    .vmag_d    (vmag_d)
  );

  tb_ads_model u_ads (
    .sen   (adc_pins.adc_sen),
    .sclk  (adc_pins.adc_sclk),
    .sdata (adc_pins.adc_sdata),
    .sdout (model_sdout)
  );

  initial begin
    clk_usb = 1'b0;
    forever #20 clk_usb = ~clk_usb;  // 40 ns
  end

  // pin image for an ADC control byte, bit 5 ignored
  function automatic adc_pins_t pins_of(input reg_byte_t d);
    adc_pins_t p;
    p = '{adc_reset: d[7], adc_sen: d[6], adc_sdata: d[4], adc_dfs: d[3],
          adc_oe: !d[2], adc_sclk: d[0]};
    return p;
  endfunction

  // serial port byte: reset 0, dfs 0, oe on
  function automatic reg_byte_t ctrl_byte(input logic sen, input logic sda,
                                          input logic sclk, input logic cap);
    return {1'b0, sen, 1'b0, sda, 2'b00, cap, sclk};
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != err_base) tests_failed++;
    $display("test %-12s %s", name, (errors == err_base) ? "ok" : "failed");
    err_base = errors;
  endtask

  task automatic abort_timeout(input string what);
    $display("timeout: %s", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  // reference update for a write sampled by the DUT
  task automatic model_write(input reg_addr_t a, input reg_byte_t d, input logic sd);
    if (a == ADC_A) begin
      exp_pins = pins_of(d);
      if (d[1]) exp_capture = {exp_capture[6:0], sd};  // shift in at bit 0
    end else if (a == VMAG_A) begin
      exp_vmag = d[4:0];
    end
  endtask

  // one-cycle write pulse, returns mid-cycle after the pins moved
  task automatic apply_write(input reg_addr_t a, input reg_byte_t d);
    logic seen;
    @(posedge clk_usb);
    reg_req <= '{address: a, wdata: d, read: 1'b0, write: 1'b1};
    @(negedge clk_usb);
    seen = adc_sdout;  // level the DUT samples at the next edge
    @(posedge clk_usb);
    reg_req.write <= 1'b0;
    model_write(a, d, seen);
    @(negedge clk_usb);
  endtask

  task automatic read_reg(input reg_addr_t a, output reg_byte_t d);
    @(posedge clk_usb);
    reg_req <= '{address: a, wdata: 8'h00, read: 1'b1, write: 1'b0};
    @(posedge clk_usb);
    reg_req.read <= 1'b0;
    @(negedge clk_usb);
    d = reg_datao;
  endtask

  // bit-bang one byte, sclk low then high per bit
  task automatic shift_byte(input reg_byte_t b, input logic cap);
    for (int i = 7; i >= 0; i--) begin
      apply_write(ADC_A, ctrl_byte(1'b0, b[i], 1'b0, 1'b0));
      apply_write(ADC_A, ctrl_byte(1'b0, b[i], 1'b1, cap));
    end
  endtask

  task automatic wait_store(input int base);
    int n;
    n = 0;
    while (u_ads.wr_count == base && n < 32) begin
      @(negedge clk_usb);
      n++;
    end
    if (u_ads.wr_count == base) abort_timeout("ADC model never stored the serial write");
  endtask

  initial begin : main
    reg_byte_t d;
    reg_byte_t rd;
    reg_byte_t sa;
    reg_addr_t a;
    int        base;
    logic      seen;
    reset_i    = 1'b1;
    reg_req    = '0;
    use_model  = 1'b0;
    rand_sdout = 1'b0;
    base = $urandom(32'h4b65_6a7e);  // single seed for the run
    repeat (16) @(posedge clk_usb);
    reset_i <= 1'b0;
    @(negedge clk_usb);

    // 1: reset values
    exp_pins = '{adc_reset: 0, adc_sen: 1, adc_sdata: 0, adc_dfs: 0, adc_oe: 1, adc_sclk: 1};
    exp_capture = '0;
    exp_vmag    = '0;
    compare("adc_pins", exp_pins, adc_pins);
    compare("vmag_d", 0, vmag_d);
    compare("reg_datao", 0, reg_datao);
    finish_test("reset");

    // 2: random control writes
    repeat (20) begin
      @(posedge clk_usb) rand_sdout <= $urandom;
      apply_write(ADC_A, reg_byte_t'($urandom));
      compare("adc_pins", exp_pins, adc_pins);
    end
    finish_test("pin_writes");

    // 3: held write counts once, first cycle data
    d = reg_byte_t'($urandom) | 8'h02;  // capture on
    @(posedge clk_usb);
    reg_req <= '{address: ADC_A, wdata: d, read: 1'b0, write: 1'b1};
    rand_sdout <= $urandom;
    @(negedge clk_usb) seen = adc_sdout;
    repeat ($urandom_range(5, 3)) begin
      @(posedge clk_usb);
      reg_req.wdata <= reg_byte_t'($urandom);
      rand_sdout    <= $urandom;
      @(negedge clk_usb) compare("adc_pins held", pins_of(d), adc_pins);
    end
    @(posedge clk_usb) reg_req.write <= 1'b0;
    model_write(ADC_A, d, seen);
    read_reg(ADC_A, rd);
    compare("capture_data", exp_capture, rd);
    finish_test("held_write");

    // 4: gain, unmapped and idle reads
    repeat (8) begin
      apply_write(VMAG_A, reg_byte_t'($urandom));
      compare("vmag_d", exp_vmag, vmag_d);
      read_reg(VMAG_A, rd);
      compare("reg_datao gain", {3'b000, exp_vmag}, rd);
    end
    repeat (8) begin
      do a = reg_addr_t'($urandom); while (a == ADC_A || a == VMAG_A);
      read_reg(a, rd);
      compare("reg_datao unmapped", 0, rd);
      @(posedge clk_usb) reg_req <= '{address: ADC_A, wdata: 8'h00, read: 1'b0, write: 1'b0};
      @(posedge clk_usb);
      @(negedge clk_usb) compare("reg_datao idle", 0, reg_datao);
    end
    finish_test("gain_reads");

    // 5: serial register write, then read back through capture
    use_model = 1'b1;
    sa   = reg_byte_t'($urandom_range(127, 0));
    d    = reg_byte_t'($urandom);
    base = u_ads.wr_count;
    apply_write(ADC_A, ctrl_byte(1'b1, 1'b0, 1'b1, 1'b0));  // idle
    apply_write(ADC_A, ctrl_byte(1'b0, 1'b0, 1'b1, 1'b0));  // sen low
    shift_byte(sa, 1'b0);
    shift_byte(d, 1'b0);
    apply_write(ADC_A, ctrl_byte(1'b1, 1'b0, 1'b1, 1'b0));
    wait_store(base);
    compare("ads mem", d, u_ads.mem[sa]);
    apply_write(ADC_A, ctrl_byte(1'b0, 1'b0, 1'b1, 1'b0));
    shift_byte(sa | 8'h80, 1'b0);  // read command
    shift_byte(8'h00, 1'b1);       // clock data into capture
    apply_write(ADC_A, ctrl_byte(1'b1, 1'b0, 1'b1, 1'b0));
    read_reg(ADC_A, rd);
    compare("reg_datao serial", d, rd);
    compare("capture model", d, exp_capture);
    use_model = 1'b0;
    finish_test("serial_port");

    // 6: mixed traffic
    repeat (40) begin
      case ($urandom_range(3, 0))
        0: begin
          @(posedge clk_usb) rand_sdout <= $urandom;
          apply_write(ADC_A, reg_byte_t'($urandom));
          compare("adc_pins", exp_pins, adc_pins);
        end
        1: begin
          read_reg(ADC_A, rd);
          compare("reg_datao capture", exp_capture, rd);
        end
        2: begin
          apply_write(VMAG_A, reg_byte_t'($urandom));
          compare("vmag_d", exp_vmag, vmag_d);
        end
        default: begin
          read_reg(VMAG_A, rd);
          compare("reg_datao gain", {3'b000, exp_vmag}, rd);
        end
      endcase
    end
    read_reg(ADC_A, rd);
    compare("reg_datao capture", exp_capture, rd);
    finish_test("mixed");

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* tb_ads_model.sv */
`timescale 1ns/1ps

// behavioral ADC serial register port
// frame while sen low: 8 address bits then 8 data bits, MSB first
module tb_ads_model (
  input  logic sen,    // active low frame
  input  logic sclk,
  input  logic sdata,
  output logic sdout
);

  logic [7:0] mem [0:255];  // register file
  logic [7:0] addr_sr;      // address shift, bit 7 set = read
  logic [7:0] data_sr;      // write data shift
  int         bit_cnt;      // rising sclk edges in this frame
  int         wr_count;     // register writes stored so far

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'ha5;  // fill from the whole address
    end
    addr_sr  = '0;
    data_sr  = '0;
    bit_cnt  = 0;
    wr_count = 0;
    sdout    = 1'b0;
  end

  always @(negedge sen) bit_cnt = 0;  // new frame
  always @(posedge sen) sdout = 1'b0;  // frame over, release sdout

  // sdata sampled on rising sclk
  always @(posedge sclk) begin
    if (sen === 1'b0) begin
      if (bit_cnt < 8) addr_sr = {addr_sr[6:0], sdata};
      else if (bit_cnt < 16) data_sr = {data_sr[6:0], sdata};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 16 && !addr_sr[7]) begin
        mem[addr_sr] = data_sr;  // write complete
        wr_count     = wr_count + 1;
      end
    end
  end

  // read data moves on falling sclk, MSB first
  always @(negedge sclk) begin
    if (sen === 1'b0 && addr_sr[7] && bit_cnt >= 8 && bit_cnt < 16) begin
      sdout = mem[{1'b0, addr_sr[6:0]}][15 - bit_cnt];
    end else begin
      sdout = 1'b0;
    end
  end

endmodule

/* adc_ctrl_top.sv */
`timescale 1ns/1ps

// ADC control register block
// bus decode -> pin / gain state -> read-back
module adc_ctrl_top (
  input  logic                    clk_usb,
  input  logic                    reset_i,
  input  adc_ctrl_pkg::reg_req_t  reg_req,    // host byte bus
  output adc_ctrl_pkg::reg_byte_t reg_datao,  // to the bus owner's tristate
  output adc_ctrl_pkg::adc_pins_t adc_pins,   // ADC serial / control pins
  input  logic                    adc_sdout,  // ADC OVR/SDOUT pin
  output adc_ctrl_pkg::vmag_t     vmag_d      // VGA gain code
);

  import adc_ctrl_pkg::*;

  reg_strobe_t strobe;        // decoded actions
  reg_byte_t   capture_data;  // serial capture register

  // input side
  reg_bus_decode u_decode (
    .clk_usb (clk_usb),
    .reset_i (reset_i),
    .reg_req (reg_req),
    .strobe  (strobe)
  );

  // pin, capture and gain state
  adc_serial_ctrl u_serial (
    .clk_usb      (clk_usb),
    .reset_i      (reset_i),
    .strobe       (strobe),
    .adc_sdout    (adc_sdout),
    .adc_pins     (adc_pins),
    .capture_data (capture_data),
    .vmag         (vmag_d)         // also fed back for reads
  );

  // output side
  reg_readback u_readback (
    .clk_usb      (clk_usb),
    .reset_i      (reset_i),
    .reg_req      (reg_req),
    .capture_data (capture_data),
    .vmag         (vmag_d),
    .reg_datao    (reg_datao)
  );

endmodule

/* reg_readback.sv */
`timescale 1ns/1ps
`include "adc_ctrl_config.svh"

// registered read mux that returns zero when idle or unmapped
module reg_readback (
  input  logic                    clk_usb,
  input  logic                    reset_i,
  input  adc_ctrl_pkg::reg_req_t  reg_req,
  input  adc_ctrl_pkg::reg_byte_t capture_data,
  input  adc_ctrl_pkg::vmag_t     vmag,
  output adc_ctrl_pkg::reg_byte_t reg_datao
);

  import adc_ctrl_pkg::*;

  reg_byte_t rd_sel;  // value for the addressed register

  // address select
  always_comb begin
    case (reg_req.address)
      reg_addr_t'(`ADC_CTRL_ADDR):  rd_sel = capture_data;
      reg_addr_t'(`VMAG_CTRL_ADDR): rd_sel = reg_byte_t'(vmag);  // zero-extended
      default:                      rd_sel = '0;
    endcase
  end

  // one cycle read latency
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      reg_datao <= '0;
    end else if (reg_req.read) begin
      reg_datao <= rd_sel;
    end else begin
      reg_datao <= '0;  // bus owner sees zero when idle
    end
  end

  // no stale data once read drops
  a_idle_zero : assert property (
    @(posedge clk_usb) disable iff (reset_i)
    !reg_req.read |=> (reg_datao == '0)
  ) else $error("reg_datao nonzero after a cycle with read low");

endmodule

/* adc_serial_ctrl.sv */
`timescale 1ns/1ps
`include "adc_ctrl_config.svh"

// ADC pin state, serial capture register and VGA gain
//
// software bit-bangs the ADC serial port
// every ADC control write sets the six pins at once
// a set capture bit also shifts the current sdout level into capture_data
module adc_serial_ctrl (
  input  logic                      clk_usb,
  input  logic                      reset_i,
  input  adc_ctrl_pkg::reg_strobe_t strobe,
  input  logic                      adc_sdout,     // ADC serial out shared with OVR
  output adc_ctrl_pkg::adc_pins_t   adc_pins,
  output adc_ctrl_pkg::reg_byte_t   capture_data,
  output adc_ctrl_pkg::vmag_t       vmag
);

  import adc_ctrl_pkg::*;

  adc_pins_t pins_nxt;  // pin image decoded from wdata
  logic      capture;   // shift request in this write

  // byte to pin mapping with bit 5 unused
  always_comb begin
    pins_nxt.adc_reset = strobe.wdata[`ADC_BIT_RESET];
    pins_nxt.adc_sen   = strobe.wdata[`ADC_BIT_SEN];
    pins_nxt.adc_sdata = strobe.wdata[`ADC_BIT_SDATA];
    pins_nxt.adc_dfs   = strobe.wdata[`ADC_BIT_DFS];
    pins_nxt.adc_oe    = ~strobe.wdata[`ADC_BIT_OE_N];  // inverted on the bus
    pins_nxt.adc_sclk  = strobe.wdata[`ADC_BIT_SCLK];
  end

  assign capture = strobe.wdata[`ADC_BIT_CAPTURE];

  // pin register
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      adc_pins.adc_reset <= 1'b0;
      adc_pins.adc_sen   <= 1'b1;  // serial port idle
      adc_pins.adc_sdata <= 1'b0;
      adc_pins.adc_dfs   <= 1'b0;
      adc_pins.adc_oe    <= 1'b1;  // outputs on
      adc_pins.adc_sclk  <= 1'b1;
    end else if (strobe.adc_wr) begin
      adc_pins <= pins_nxt;
    end
  end

  // capture shift register with sdout entering at bit 0
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      capture_data <= '0;
    end else if (strobe.adc_wr && capture) begin
      capture_data <= {capture_data[`REG_BYTE_W-2:0], adc_sdout};
    end
  end

  // level triggered VGA gain
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      vmag <= '0;
    end else if (strobe.vmag_wr) begin
      vmag <= vmag_t'(strobe.wdata[`VMAG_W-1:0]);  // upper bits dropped
    end
  end

  // capture register only moves on a capture write
  a_capture_after_wr : assert property (
    @(posedge clk_usb) disable iff (reset_i)
    !$stable(capture_data) |-> $past(strobe.adc_wr)
  ) else $error("capture_data changed without adc_wr");

endmodule

/* reg_bus_decode.sv */
`timescale 1ns/1ps
`include "adc_ctrl_config.svh"

// write edge detect and address match for the host bus
module reg_bus_decode (
  input  logic                      clk_usb,
  input  logic                      reset_i,
  input  adc_ctrl_pkg::reg_req_t    reg_req,
  output adc_ctrl_pkg::reg_strobe_t strobe
);

  import adc_ctrl_pkg::*;

  logic write_q;     // write level seen last cycle
  logic write_rise;  // write low -> high
  logic hit_adc;     // address matches ADC control
  logic hit_vmag;    // address matches gain register

  // previous write level
  // cleared in reset, so a write held through reset counts as a new edge
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      write_q <= 1'b0;
    end else begin
      write_q <= reg_req.write;
    end
  end

  assign write_rise = reg_req.write & ~write_q;

  assign hit_adc  = (reg_req.address == reg_addr_t'(`ADC_CTRL_ADDR));
  assign hit_vmag = (reg_req.address == reg_addr_t'(`VMAG_CTRL_ADDR));

  // strobes are combinational off the request
  always_comb begin
    strobe.adc_wr  = write_rise & hit_adc;       // once per edge
    strobe.vmag_wr = reg_req.write & hit_vmag;   // every write cycle
    strobe.wdata   = reg_req.wdata;
  end

  // a held write must never retrigger the ADC port
  a_adc_wr_single : assert property (
    @(posedge clk_usb) disable iff (reset_i)
    strobe.adc_wr |=> !strobe.adc_wr
  ) else $error("adc_wr high on two consecutive cycles");

endmodule

/* adc_ctrl_pkg.sv */
`include "adc_ctrl_config.svh"

package adc_ctrl_pkg;

  // plain vectors with a meaning
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // register address
  typedef logic [`REG_BYTE_W-1:0] reg_byte_t;  // one bus byte
  typedef logic [`VMAG_W-1:0]     vmag_t;      // VGA gain code

  // host request, one per clk_usb cycle
  typedef struct packed {
    reg_addr_t address;  // register select
    reg_byte_t wdata;    // write data
    logic      read;     // read level
    logic      write;    // write level
  } reg_req_t;

  // decoded bus actions
  typedef struct packed {
    logic      adc_wr;   // single pulse per write edge at ADC_CTRL_ADDR
    logic      vmag_wr;  // level, follows write at VMAG_CTRL_ADDR
    reg_byte_t wdata;    // byte on the bus
  } reg_strobe_t;

  // ADC control pins, order matches the board pinout list
  typedef struct packed {
    logic adc_reset;
    logic adc_sen;    // serial enable, active low
    logic adc_sdata;
    logic adc_dfs;    // data format select
    logic adc_oe;
    logic adc_sclk;
  } adc_pins_t;

endpackage

/* adc_ctrl_config.svh */
`ifndef ADC_CTRL_CONFIG_SVH
`define ADC_CTRL_CONFIG_SVH

// register map of the ADC control block
`define ADC_CTRL_ADDR   60  // bit-bang port to the ADC serial interface
`define VMAG_CTRL_ADDR  61  // gain code of the VGA ahead of the ADC

// field widths
`define REG_ADDR_W      6   // register bus address
`define REG_BYTE_W      8   // register bus data
`define VMAG_W          5   // VGA gain code

// wdata bit positions on an ADC control write
`define ADC_BIT_RESET   7
`define ADC_BIT_SEN     6
`define ADC_BIT_SDATA   4
`define ADC_BIT_DFS     3
`define ADC_BIT_OE_N    2   // output enable, active low in the byte
`define ADC_BIT_CAPTURE 1
`define ADC_BIT_SCLK    0

`endif
